// File: cpu_bus_sm.sv
// ****************************************
// Writes only; ack in address phase is taken
// A bus error or retry is not handled
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module cpu_bus_sm (
    input  logic                       clk,
    input  logic                       reset,
    xfer_credit_if.dst                 link,
    input  logic                       bgrant,
    input  logic                       dsack,
    input  logic                       sterm,
    input  logic [dma_pkg::ADDR_W-1:0] start_addr,
    input  logic                       load_addr,
    output dma_pkg::bus_state_t        next_state,
    output logic                       half,
    output logic [dma_pkg::ADDR_W-1:0] addr,
    output logic [dma_pkg::DATA_W-1:0] data_out,
    output logic                       done
);

    dma_pkg::bus_state_t              state;
    logic [dma_pkg::DATA_W-1:0]       buf_data [dma_pkg::XFER_CREDITS];
    logic [dma_pkg::XFER_CREDITS-1:0] buf_last;
    logic [dma_pkg::BUF_IDX_W-1:0]    wr_idx;
    logic [dma_pkg::BUF_IDX_W-1:0]    rd_idx;
    logic [dma_pkg::CREDIT_W-1:0]     buf_count;
    logic [dma_pkg::ADDR_W-1:0]       run_addr;
    logic                             half_q;
    logic                             bus_cycle;
    logic                             word_done;
    logic                             half_done;
    logic [dma_pkg::DATA_W-1:0]       cur_word;

    assign cur_word  = buf_data[rd_idx];
    assign bus_cycle = (state == dma_pkg::st_addr) || (state == dma_pkg::st_data);
    // sterm ends the word at once, dsack only on the low half
    assign word_done = bus_cycle && (sterm || (dsack && half_q));
    assign half_done = bus_cycle && !sterm && dsack && !half_q;

    // Next value of the half flag, passed on for size1
    assign half = word_done ? 1'b0 : (half_done ? 1'b1 : half_q);

    // Low half goes out on the upper lanes at addr + 2
    assign addr     = run_addr + (half_q ? dma_pkg::HALF_STEP : '0);
    assign data_out = half_q ? {cur_word[dma_pkg::DATA_W/2-1:0], {(dma_pkg::DATA_W/2){1'b0}}}
                             : cur_word;

    always_comb begin
        next_state = state;
        case (state)
            dma_pkg::st_idle:    if (buf_count != '0) next_state = dma_pkg::st_req;
            dma_pkg::st_req:     if (bgrant) next_state = dma_pkg::st_own;
            // Empty buffer before the last word gives the bus back
            dma_pkg::st_own:     next_state = (buf_count != '0) ? dma_pkg::st_addr
                                                                : dma_pkg::st_release;
            dma_pkg::st_addr,
            dma_pkg::st_data: begin
                if (word_done) begin
                    next_state = buf_last[rd_idx] ? dma_pkg::st_release : dma_pkg::st_own;
                end else if (half_done) begin
                    next_state = dma_pkg::st_half;
                end else begin
                    next_state = dma_pkg::st_data;
                end
            end
            dma_pkg::st_half:    next_state = dma_pkg::st_addr;
            dma_pkg::st_release: next_state = dma_pkg::st_idle;
            default:             next_state = dma_pkg::st_idle;
        endcase
    end

    // Control registers
    always_ff @(posedge clk) begin
        if (reset) begin
            state              <= dma_pkg::st_idle;
            half_q             <= 1'b0;
            wr_idx             <= '0;
            rd_idx             <= '0;
            buf_count          <= '0;
            done               <= 1'b0;
            link.credit_return <= 1'b0;
        end else begin
            state  <= next_state;
            half_q <= half;
            if (link.word_valid) wr_idx <= wr_idx + 1'b1;
            if (word_done)       rd_idx <= rd_idx + 1'b1;
            case ({link.word_valid, word_done})
                2'b10:   buf_count <= buf_count + 1'b1;
                2'b01:   buf_count <= buf_count - 1'b1;
                default: buf_count <= buf_count;
            endcase
            // A finished word frees a buffer slot
            link.credit_return <= word_done;
            done               <= word_done && buf_last[rd_idx];
        end
    end

    // Word buffer, filled straight from the link
    always_ff @(posedge clk) begin
        if (link.word_valid) begin
            buf_data[wr_idx] <= link.word_data;
            buf_last[wr_idx] <= link.word_last;
        end
    end

    // Running address, a load overrides the increment
    always_ff @(posedge clk) begin
        if (load_addr) begin
            run_addr <= start_addr;
        end else if (word_done) begin
            run_addr <= run_addr + dma_pkg::WORD_STEP;
        end
    end

    // Memory side drives only one acknowledge kind per cycle
    a_one_ack: assert property (@(posedge clk) disable iff (reset)
        (state == dma_pkg::st_data) |-> !(dsack && sterm));

    // Credits on the FIFO side keep the buffer from overflowing
    a_buf_room: assert property (@(posedge clk) disable iff (reset)
        (link.word_valid && !word_done) |-> (buf_count != dma_pkg::CREDIT_INIT));

endmodule

`default_nettype wire

// File: cpu_sm_outputs.sv
// ****************************************
// Strobes lag the engine state one cycle
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module cpu_sm_outputs (
    input  logic                clk,
    input  logic                reset,
    input  dma_pkg::bus_state_t next_state,
    input  logic                half,
    input  logic                bgrant,
    output logic                breq,
    output logic                bgack,
    output logic                as,
    output logic                ds,
    output logic                size1
);

    logic breq_d;
    logic bgack_d;
    logic as_d;
    logic ds_d;
    logic size1_d;
    logic owned_next;
    logic cycle_next;

    always_comb begin
        // Engine holds the bus in these states
        owned_next = (next_state == dma_pkg::st_own)  || (next_state == dma_pkg::st_addr) ||
                     (next_state == dma_pkg::st_data) || (next_state == dma_pkg::st_half);
        cycle_next = (next_state == dma_pkg::st_addr) || (next_state == dma_pkg::st_data);

        // Request only while waiting for the grant
        breq_d  = (next_state == dma_pkg::st_req);
        // bgack needs a grant to start, then holds until release
        bgack_d = owned_next && (bgack || bgrant);
        // Address strobe over both phases
        as_d    = cycle_next;
        // Data strobe a cycle after the address is set up
        ds_d    = (next_state == dma_pkg::st_data);
        // Low half cycle on a 16-bit port, including its gap cycle
        size1_d = half && (cycle_next || (next_state == dma_pkg::st_half));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            breq  <= 1'b0;
            bgack <= 1'b0;
            as    <= 1'b0;
            ds    <= 1'b0;
            size1 <= 1'b0;
        end else begin
            breq  <= breq_d;
            bgack <= bgack_d;
            as    <= as_d;
            ds    <= ds_d;
            size1 <= size1_d;
        end
    end

    // ds only inside a cycle whose address phase has already been seen
    a_ds_in_as: assert property (@(posedge clk) disable iff (reset)
        ds |-> (as && $past(as)));

endmodule

`default_nettype wire

// File: dma_pkg.sv
// ****************************************
// Widths and credit count are fixed here
// Credits must not exceed the engine buffer depth
// ****************************************
`default_nettype none

package dma_pkg;

    // Transfer word and bus address widths
    localparam int unsigned DATA_W = 32;
    localparam int unsigned ADDR_W = 32;

    // Source side word FIFO
    localparam int unsigned FIFO_DEPTH = 8;
    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
    // One extra bit so a full FIFO can be told from an empty one
    localparam int unsigned FIFO_CNT_W = PTR_W + 1;
    localparam logic [FIFO_CNT_W-1:0] FIFO_FULL = FIFO_CNT_W'(FIFO_DEPTH);

    // Words the engine can hold, which is also the starting credit count
    localparam int unsigned XFER_CREDITS = 2;
    localparam int unsigned CREDIT_W = 2;
    localparam int unsigned BUF_IDX_W = $clog2(XFER_CREDITS);
    localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(XFER_CREDITS);

    // Address steps for a whole word and for the low half on a 16-bit port
    localparam logic [ADDR_W-1:0] WORD_STEP = ADDR_W'(4);
    localparam logic [ADDR_W-1:0] HALF_STEP = ADDR_W'(2);

    // Bus engine states
    typedef enum logic [2:0] {
        st_idle,    // no work
        st_req,     // bus requested, waiting for grant
        st_own,     // bus owned, pick the next word
        st_addr,    // address phase
        st_data,    // data phase, waiting for sterm or dsack
        st_half,    // gap before the low half cycle on a 16-bit port
        st_release  // hand the bus back
    } bus_state_t;

endpackage

`default_nettype wire

// File: fifo_stage.sv
// ****************************************
// Words only leave while credits remain
// src_ready is low only when the FIFO is full
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module fifo_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       src_valid,
    input  logic [dma_pkg::DATA_W-1:0] src_data,
    input  logic                       src_last,
    output logic                       src_ready,
    xfer_credit_if.src                 link
);

    // Entry holds the last flag above the data word
    logic [dma_pkg::DATA_W:0]       mem [dma_pkg::FIFO_DEPTH];
    logic [dma_pkg::PTR_W-1:0]      wr_ptr;
    logic [dma_pkg::PTR_W-1:0]      rd_ptr;
    logic [dma_pkg::FIFO_CNT_W-1:0] count;
    logic [dma_pkg::CREDIT_W-1:0]   credit;
    logic                           push;
    logic                           pop;

    // Source handshake
    assign src_ready = (count != dma_pkg::FIFO_FULL);
    assign push      = src_valid && src_ready;

    // Forward the oldest word whenever one is stored and a credit is left
    assign pop = (count != '0) && (credit != '0);

    // Word storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {src_last, src_data};
        end
    end

    // Pointers, fill level and credits
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= dma_pkg::CREDIT_INIT;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Spend and return in one cycle cancel out
            case ({link.credit_return, pop})
                2'b10:   credit <= credit + 1'b1;
                2'b01:   credit <= credit - 1'b1;
                default: credit <= credit;
            endcase
        end
    end

    // One valid cycle toward the engine per word
    always_ff @(posedge clk) begin
        if (reset) begin
            link.word_valid <= 1'b0;
        end else begin
            link.word_valid <= pop;
        end
    end

    // Word payload holds between pops
    always_ff @(posedge clk) begin
        if (pop) begin
            link.word_data <= mem[rd_ptr][dma_pkg::DATA_W-1:0];
            link.word_last <= mem[rd_ptr][dma_pkg::DATA_W];
        end
    end

    // Engine must never hand back more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credit <= dma_pkg::CREDIT_INIT);

    // Fill level must match the pointer distance or a push would overwrite a stored word
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        count[dma_pkg::PTR_W-1:0] == (wr_ptr - rd_ptr));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the DMA testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_sdmac -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_sdmac > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

# The log decides the result
if grep -q "RESULT: FAIL" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

// File: sdmac_top.sv
// ****************************************
// load_addr must precede each block's words
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module sdmac_top (
    input  logic                       clk,
    input  logic                       reset,
    // Peripheral side word source
    input  logic                       src_valid,
    input  logic [dma_pkg::DATA_W-1:0] src_data,
    input  logic                       src_last,
    output logic                       src_ready,
    // Block start address
    input  logic [dma_pkg::ADDR_W-1:0] start_addr,
    input  logic                       load_addr,
    // Processor bus
    input  logic                       bgrant,
    input  logic                       dsack,
    input  logic                       sterm,
    output logic                       breq,
    output logic                       bgack,
    output logic                       as,
    output logic                       ds,
    output logic                       size1,
    output logic [dma_pkg::ADDR_W-1:0] addr,
    output logic [dma_pkg::DATA_W-1:0] data_out,
    output logic                       done
);

    dma_pkg::bus_state_t next_state;
    logic                half;

    // Credit link between FIFO and engine
    xfer_credit_if link0 (
        .clk   (clk),
        .reset (reset)
    );

    fifo_stage fifo0 (
        .clk       (clk),
        .reset     (reset),
        .src_valid (src_valid),
        .src_data  (src_data),
        .src_last  (src_last),
        .src_ready (src_ready),
        .link      (link0.src)
    );

    cpu_bus_sm sm0 (
        .clk        (clk),
        .reset      (reset),
        .link       (link0.dst),
        .bgrant     (bgrant),
        .dsack      (dsack),
        .sterm      (sterm),
        .start_addr (start_addr),
        .load_addr  (load_addr),
        .next_state (next_state),
        .half       (half),
        .addr       (addr),
        .data_out   (data_out),
        .done       (done)
    );

    // Registered strobes from the engine's next state
    cpu_sm_outputs out0 (
        .clk        (clk),
        .reset      (reset),
        .next_state (next_state),
        .half       (half),
        .bgrant     (bgrant),
        .breq       (breq),
        .bgack      (bgack),
        .as         (as),
        .ds         (ds),
        .size1      (size1)
    );

endmodule

`default_nettype wire

// File: tb_sdmac.sv
// ****************************************
// Bus model takes the port width from address bit 8
// Blocks must not cross a bit 8 boundary
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module tb_sdmac;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int SLOW_WAIT    = 16;
    localparam int NUM_BLOCKS   = 4;

    // Block table with start address, word count, slow acknowledge and expected src_ready stall
    localparam logic [31:0] BLK_ADDR  [NUM_BLOCKS] = '{32'h0000_1000, 32'h0000_2100,
                                                      32'h0000_3000, 32'h0000_4340};
    localparam int          BLK_WORDS [NUM_BLOCKS] = '{4, 3, 12, 5};
    localparam logic        BLK_SLOW  [NUM_BLOCKS] = '{1'b0, 1'b0, 1'b1, 1'b0};
    localparam logic        BLK_STALL [NUM_BLOCKS] = '{1'b0, 1'b0, 1'b1, 1'b0};

    logic        clk = 1'b0;
    logic        reset;
    logic        src_valid;
    logic [31:0] src_data;
    logic        src_last;
    logic        src_ready;
    logic [31:0] start_addr;
    logic        load_addr;
    logic        bgrant;
    logic        dsack;
    logic        sterm;
    logic        breq;
    logic        bgack;
    logic        as;
    logic        ds;
    logic        size1;
    logic [31:0] addr;
    logic [31:0] data_out;
    logic        done;

    // Expected bus cycles in order
    logic [31:0] exp_addr  [$];
    logic [31:0] exp_data  [$];
    logic        exp_full  [$];
    logic        exp_size1 [$];

    int          pushed;
    int          completed;
    int          done_count;
    int          stall_count;
    logic        slow_ack;
    logic [15:0] stim_lfsr;

    sdmac_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .src_valid  (src_valid),
        .src_data   (src_data),
        .src_last   (src_last),
        .src_ready  (src_ready),
        .start_addr (start_addr),
        .load_addr  (load_addr),
        .bgrant     (bgrant),
        .dsack      (dsack),
        .sterm      (sterm),
        .breq       (breq),
        .bgack      (bgack),
        .as         (as),
        .ds         (ds),
        .size1      (size1),
        .addr       (addr),
        .data_out   (data_out),
        .done       (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] st);
        return {st[14:0], st[15] ^ st[13] ^ st[12] ^ st[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_next(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            $display("FAIL %0t ns: %s, got %h, expected %h", $time, what, got, want);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // A 16-bit port takes the high half first, then the low half at +2 with size1
    task automatic add_expected(input logic [31:0] wa, input logic [31:0] word);
        if (wa[8]) begin
            exp_addr.push_back(wa);
            exp_data.push_back({word[31:16], 16'h0000});
            exp_full.push_back(1'b0);
            exp_size1.push_back(1'b0);
            exp_addr.push_back(wa + 32'd2);
            exp_data.push_back({word[15:0], 16'h0000});
            exp_full.push_back(1'b0);
            exp_size1.push_back(1'b1);
        end else begin
            exp_addr.push_back(wa);
            exp_data.push_back(word);
            exp_full.push_back(1'b1);
            exp_size1.push_back(1'b0);
        end
    endtask

    // Handshake counts on the same edge the DUT uses
    always @(posedge clk) begin
        if (reset) begin
            pushed    = 0;
            completed = 0;
        end else begin
            if (src_valid && src_ready) pushed++;
            if (as && (sterm || (dsack && size1))) completed++;
        end
    end

    initial begin : stimulus
        logic [31:0] word;
        logic [31:0] gap;
        int          stall_before;
        reset      = 1'b1;
        src_valid  = 1'b0;
        src_data   = '0;
        src_last   = 1'b0;
        start_addr = '0;
        load_addr  = 1'b0;
        slow_ack   = 1'b0;
        stim_lfsr  = 16'd82;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        // Everything quiet straight out of reset
        check_value(32'({breq, bgack, as, ds, size1, done}), 32'd0, "strobes after reset");
        check_value(32'(src_ready), 32'd1, "src_ready after reset");
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            start_addr   = BLK_ADDR[b];
            load_addr    = 1'b1;
            slow_ack     = BLK_SLOW[b];
            stall_before = stall_count;
            @(negedge clk);
            load_addr = 1'b0;
            for (int w = 0; w < BLK_WORDS[b]; w++) begin
                // Slow blocks push back to back to fill the FIFO
                if (!BLK_SLOW[b]) begin
                    take_bits(stim_lfsr, 2, gap);
                    src_valid = 1'b0;
                    repeat (gap) @(negedge clk);
                end
                take_bits(stim_lfsr, 32, word);
                add_expected(BLK_ADDR[b] + 32'(4 * w), word);
                src_valid = 1'b1;
                src_data  = word;
                src_last  = (w == BLK_WORDS[b] - 1);
                // src_ready holds until the next rising edge
                while (!src_ready) @(negedge clk);
                @(negedge clk);
            end
            src_valid = 1'b0;
            src_last  = 1'b0;
            while (done_count < b + 1) @(negedge clk);
            check_value(32'(stall_count != stall_before), 32'(BLK_STALL[b]),
                        "src_ready stall seen in block");
            check_value(32'(exp_addr.size()), 32'd0, "bus writes missing at done");
        end
        repeat (4) @(negedge clk);
        if (done_count == NUM_BLOCKS && exp_addr.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Run ended with %0d done pulses for %0d blocks and %0d bus cycles unseen",
                     done_count, NUM_BLOCKS, exp_addr.size());
            $display("RESULT: FAIL");
            $fatal(1, "end of run check failed");
        end
    end

    // Memory bus model and bus checks sample outputs before driving inputs
    initial begin : bus_model
        logic [15:0] bus_lfsr;
        logic [31:0] r;
        logic [31:0] want_addr;
        logic [31:0] want_data;
        logic [31:0] seen_data;
        logic        want_full;
        logic        want_size1;
        int          grant_wait;
        int          ack_wait;
        int          outstanding;
        logic        acked;
        logic        as_prev;
        logic        bgack_prev;
        logic        done_prev;
        logic        req_grant;
        bgrant      = 1'b0;
        dsack       = 1'b0;
        sterm       = 1'b0;
        bus_lfsr    = 16'd82;
        grant_wait  = -1;
        ack_wait    = -1;
        acked       = 1'b0;
        as_prev     = 1'b0;
        bgack_prev  = 1'b0;
        done_prev   = 1'b0;
        req_grant   = 1'b0;
        done_count  = 0;
        stall_count = 0;
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (as) check_value(32'(bgack), 32'd1, "as high without bgack");
                if (ds) check_value(32'(as), 32'd1, "ds high without as");
                if (bgack && !bgack_prev) begin
                    check_value(32'(req_grant), 32'd1, "bgack rose without breq and bgrant");
                end
                if (done) begin
                    check_value(32'(done_prev), 32'd0, "done longer than one cycle");
                    check_value(32'(bgack), 32'd0, "bgack still high at done");
                    done_count++;
                end
                // New bus cycle at the rising edge of as
                if (as && !as_prev) begin
                    check_value(32'(exp_addr.size() != 0), 32'd1, "bus cycle with a word due");
                    want_addr  = exp_addr.pop_front();
                    want_data  = exp_data.pop_front();
                    want_full  = exp_full.pop_front();
                    want_size1 = exp_size1.pop_front();
                    seen_data  = want_full ? data_out : {data_out[31:16], 16'h0000};
                    check_value(addr, want_addr, "bus address");
                    check_value(seen_data, want_data, "bus write data");
                    check_value(32'(size1), 32'(want_size1), "size1 on bus cycle");
                end
                // FIFO plus engine buffer bound the words in flight
                outstanding = pushed - completed;
                if (!src_ready) begin
                    stall_count++;
                    check_value(32'(outstanding >= dma_pkg::FIFO_DEPTH), 32'd1,
                                "src_ready low with room left");
                end
                check_value(32'(outstanding <= dma_pkg::FIFO_DEPTH + dma_pkg::XFER_CREDITS),
                            32'd1, "more words in flight than capacity");
            end
            // Drive the bus for the next edge
            sterm = 1'b0;
            dsack = 1'b0;
            if (reset || !breq) begin
                bgrant     = 1'b0;
                grant_wait = -1;
            end else if (!bgrant) begin
                if (grant_wait < 0) begin
                    take_bits(bus_lfsr, 2, r);
                    grant_wait = int'(r);
                end
                if (grant_wait == 0) bgrant = 1'b1;
                else grant_wait--;
            end
            req_grant = breq && bgrant;
            if (reset || !as) begin
                acked    = 1'b0;
                ack_wait = -1;
            end else if (!acked) begin
                if (ack_wait < 0) begin
                    take_bits(bus_lfsr, 2, r);
                    ack_wait = int'(r) + (slow_ack ? SLOW_WAIT : 0);
                end
                if (ack_wait == 0) begin
                    acked = 1'b1;
                    if (addr[8]) dsack = 1'b1;
                    else sterm = 1'b1;
                end else begin
                    ack_wait--;
                end
            end
            as_prev    = as;
            bgack_prev = bgack;
            done_prev  = done;
        end
    end

    // Watchdog sized from the block table
    initial begin : watchdog
        int total_words;
        total_words = 0;
        for (int b = 0; b < NUM_BLOCKS; b++) total_words += BLK_WORDS[b];
        #(CLK_PERIOD * (total_words * 40 + RESET_CYCLES + 200));
        $display("Timed out: the DMA did not finish all blocks in the allowed time");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: verilog.f
dma_pkg.sv
xfer_credit_if.sv
fifo_stage.sv
cpu_bus_sm.sv
cpu_sm_outputs.sv
sdmac_top.sv
tb_sdmac.sv

// File: xfer_credit_if.sv
// ****************************************
// Credit link without a ready signal
// The sender owns the credits
// ****************************************
`timescale 1ns/100ps
`default_nettype none

interface xfer_credit_if (
    input logic clk,
    input logic reset
);

    logic                       word_valid;
    logic [dma_pkg::DATA_W-1:0] word_data;
    logic                       word_last;
    // One pulse gives one credit back to the sender
    logic                       credit_return;

    modport src (
        input  clk,
        input  reset,
        output word_valid,
        output word_data,
        output word_last,
        input  credit_return
    );

    modport dst (
        input  clk,
        input  reset,
        input  word_valid,
        input  word_data,
        input  word_last,
        output credit_return
    );

    // Each word passes through st_own before its bus cycle so returns never come back to back
    a_credit_spacing: assert property (@(posedge clk) disable iff (reset)
        credit_return |=> !credit_return);

endinterface

`default_nettype wire
